/* obj_video_pkg.sv */
`default_nettype none

package obj_video_pkg;

    localparam int LAST_ACTIVE_LINE = 223;  // last line that gets scanned
    localparam int ACTIVE_WIDTH     = 320;  // pixels streamed per line
    localparam int LB_SIZE          = 512;  // entries in one line buffer half

    typedef logic [8:0] vpos_t;             // line number
    typedef logic [8:0] xpos_t;             // horizontal position, wraps at 512
    typedef logic [9:0] lb_addr_t;          // {half, x}

    typedef logic [3:0] color_t;            // colour 0 is see-through
    typedef logic [6:0] pal_t;
    typedef logic [1:0] prio_t;

    // one line buffer entry, also the streamed pixel
    typedef struct packed {
        prio_t  prio;
        pal_t   pal;
        color_t color;
    } lb_pixel_t;

endpackage

`default_nettype wire

/* obj_table_pkg.sv */
`default_nettype none

package obj_table_pkg;

    localparam int OBJ_COUNT = 32;
    localparam int TBL_WORDS = 256;     // 32 objects x 8 word slots
    localparam int CMD_DEPTH = 4;       // FIFO depth = credits after reset

    typedef logic [4:0]  obj_idx_t;
    typedef logic [2:0]  word_idx_t;    // words 0..5 used
    typedef logic [7:0]  tbl_addr_t;    // {object, word}
    typedef logic [15:0] tbl_word_t;
    typedef logic [15:0] offset_t;
    typedef logic [2:0]  bank_t;
    typedef logic [2:0]  credit_t;
    typedef logic [1:0]  cmd_ptr_t;
    typedef logic [3:0]  pix_idx_t;     // pixel inside a 16 pixel strip
    typedef logic [22:0] rom_addr_t;    // {bank, offset, pixel}

    // which word of an entry holds what
    localparam word_idx_t W_ATTR   = 3'd0;  // end, hide, bank, top line
    localparam word_idx_t W_OFFSET = 3'd1;
    localparam word_idx_t W_POS    = 3'd2;  // pitch and xpos
    localparam word_idx_t W_PRIO   = 3'd3;
    localparam word_idx_t W_FLIP   = 3'd4;
    localparam word_idx_t W_SIZE   = 3'd5;  // height and palette

    // field positions inside the words
    localparam int END_BIT    = 15;
    localparam int HIDE_BIT   = 14;
    localparam int BANK_LSB   = 9;
    localparam int TOP_LSB    = 0;
    localparam int PITCH_LSB  = 9;
    localparam int PITCH_W    = 7;      // signed
    localparam int XPOS_LSB   = 0;
    localparam int PRIO_LSB   = 12;
    localparam int HFLIP_BIT  = 14;
    localparam int HEIGHT_LSB = 8;
    localparam int HEIGHT_W   = 8;
    localparam int PAL_LSB    = 0;

    typedef struct packed {
        obj_video_pkg::xpos_t xpos;
        offset_t              offset;
        bank_t                bank;
        obj_video_pkg::prio_t prio;
        obj_video_pkg::pal_t  pal;
        logic                 hflip;
    } draw_cmd_t;

endpackage

`default_nettype wire

/* obj_table_ram.sv */
`timescale 1ns/1ps
`default_nettype none

// object table, CPU loads it during vertical blanking
// while the scanner reads entries and writes offsets back
module obj_table_ram
    import obj_table_pkg::*;
(
    input  wire            clk,

    // CPU side, write only
    input  wire            cpu_we,
    input  wire tbl_addr_t cpu_addr,
    input  wire tbl_word_t cpu_data,

    // scanner side
    input  wire tbl_addr_t tbl_addr,
    input  wire            tbl_we,
    input  wire tbl_word_t tbl_din,
    output tbl_word_t      tbl_dout
);

    tbl_word_t mem [TBL_WORDS];

    // the two writers never meet: CPU only writes outside the active lines
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_data;
        end
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_din;   // offset write-back
        end
    end

    // read data one cycle after the address
    always_ff @(posedge clk) begin
        tbl_dout <= mem[tbl_addr];
    end

endmodule

`default_nettype wire

/* obj_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module obj_scan
    import obj_video_pkg::*;
    import obj_table_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            hstart,
    input  wire vpos_t     vrender,

    output tbl_addr_t      tbl_addr,
    output logic           tbl_we,
    output tbl_word_t      tbl_din,
    input  wire tbl_word_t tbl_dout,

    output logic           cmd_valid,
    output draw_cmd_t      cmd,
    input  wire            cmd_credit
);

    typedef enum logic [2:0] {
        S_IDLE, S_FETCH, S_CHECK, S_WRITEBACK, S_ISSUE, S_DONE
    } scan_state_t;

    scan_state_t st;
    obj_idx_t    obj;
    word_idx_t   word;          // address of the word being fetched
    vpos_t       line;          // line latched at hstart
    credit_t     credits;

    // fields of the current entry
    logic                is_end;
    logic                hide;
    logic                hflip;
    vpos_t               top;
    bank_t               bank;
    offset_t             offset;
    logic [PITCH_W-1:0]  pitch;
    xpos_t               xpos;
    prio_t               prio;
    logic [HEIGHT_W-1:0] height;
    pal_t                pal;

    logic [$bits(vpos_t):0] bottom;   // one past the last line
    logic    visible;
    logic    last_obj;
    offset_t next_offset;

    assign bottom   = {1'b0, top} + {2'b0, height};
    assign visible  = !hide && line >= top && {1'b0, line} < bottom;
    assign last_obj = obj == obj_idx_t'(OBJ_COUNT - 1);
    // first line keeps the stored offset, later lines step by pitch
    assign next_offset = line == top ? offset :
        offset + {{($bits(offset_t) - PITCH_W){pitch[PITCH_W-1]}}, pitch};

    assign tbl_addr  = {obj, st == S_WRITEBACK ? W_OFFSET : word};
    assign tbl_we    = st == S_WRITEBACK;
    assign tbl_din   = offset;
    assign cmd_valid = st == S_ISSUE && credits != '0;
    assign cmd       = '{xpos: xpos, offset: offset, bank: bank, prio: prio,
                         pal: pal, hflip: hflip};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= credit_t'(CMD_DEPTH);
        end else if (cmd_valid && !cmd_credit) begin
            credits <= credits - 1'b1;
        end else if (!cmd_valid && cmd_credit) begin
            credits <= credits + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st   <= S_IDLE;
            obj  <= '0;
            word <= '0;
            line <= '0;
        end else begin
            case (st)
                S_IDLE: if (hstart && vrender <= vpos_t'(LAST_ACTIVE_LINE)) begin
                    line <= vrender;
                    obj  <= '0;
                    word <= '0;
                    st   <= S_FETCH;
                end
                S_FETCH: begin
                    word <= word + 1'b1;
                    if (word == W_SIZE + 3'd1) begin   // last word is in
                        st <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (is_end) begin
                        st <= S_DONE;
                    end else if (visible) begin
                        st <= S_WRITEBACK;
                    end else if (last_obj) begin
                        st <= S_DONE;
                    end else begin
                        obj  <= obj + 1'b1;
                        word <= '0;
                        st   <= S_FETCH;
                    end
                end
                S_WRITEBACK: st <= S_ISSUE;
                S_ISSUE: if (credits != '0) begin   // stall here without credit
                    obj  <= obj + 1'b1;
                    word <= '0;
                    st   <= last_obj ? S_DONE : S_FETCH;
                end
                S_DONE: st <= S_IDLE;
                default: st <= S_IDLE;
            endcase
        end
    end

    // data lags the address by one, so word-1 is on tbl_dout
    always_ff @(posedge clk) begin
        if (st == S_FETCH && word != W_ATTR) begin
            case (word - 3'd1)
                W_ATTR: begin
                    is_end <= tbl_dout[END_BIT];
                    hide   <= tbl_dout[HIDE_BIT];
                    bank   <= tbl_dout[BANK_LSB +: $bits(bank_t)];
                    top    <= tbl_dout[TOP_LSB +: $bits(vpos_t)];
                end
                W_OFFSET: offset <= tbl_dout;
                W_POS: begin
                    pitch <= tbl_dout[PITCH_LSB +: PITCH_W];
                    xpos  <= tbl_dout[XPOS_LSB +: $bits(xpos_t)];
                end
                W_PRIO: prio  <= tbl_dout[PRIO_LSB +: $bits(prio_t)];
                W_FLIP: hflip <= tbl_dout[HFLIP_BIT];
                W_SIZE: begin
                    height <= tbl_dout[HEIGHT_LSB +: HEIGHT_W];
                    pal    <= tbl_dout[PAL_LSB +: $bits(pal_t)];
                end
                default: ;
            endcase
        end
        if (st == S_CHECK && visible) begin
            offset <= next_offset;  // value for write-back and the command
        end
    end

endmodule

`default_nettype wire

/* obj_draw.sv */
`timescale 1ns/1ps
`default_nettype none

module obj_draw
    import obj_video_pkg::*;
    import obj_table_pkg::*;
(
    input  wire            clk,
    input  wire            rst,

    input  wire            cmd_valid,
    input  wire draw_cmd_t cmd,
    output logic           cmd_credit,

    output rom_addr_t      rom_addr,
    input  wire color_t    rom_data,

    output logic           lb_we,
    output xpos_t          lb_x,
    output lb_pixel_t      lb_pix
);

    typedef enum logic [1:0] {
        D_IDLE, D_FETCH, D_DRAIN
    } draw_state_t;

    draw_cmd_t   fifo [CMD_DEPTH];
    cmd_ptr_t    wr_ptr;
    cmd_ptr_t    rd_ptr;
    credit_t     fill;          // queued commands
    logic        pop;

    draw_state_t st;
    draw_cmd_t   cur;           // command being drawn
    pix_idx_t    pix;
    logic        wr_pend;       // ROM answer due this cycle
    xpos_t       wr_x;

    assign pop        = st == D_IDLE && fill != '0;
    assign cmd_credit = pop;    // slot freed, hand the credit back

    // command FIFO, credits keep it from overflowing
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            fifo[wr_ptr] <= cmd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (cmd_valid && !pop) begin
                fill <= fill + 1'b1;
            end else if (!cmd_valid && pop) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // pop, 16 fetches, drain
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st      <= D_IDLE;
            pix     <= '0;
            wr_pend <= 1'b0;
        end else begin
            wr_pend <= st == D_FETCH;
            case (st)
                D_IDLE: if (pop) begin
                    pix <= '0;
                    st  <= D_FETCH;
                end
                D_FETCH: begin
                    pix <= pix + 1'b1;
                    if (pix == '1) begin
                        st <= D_DRAIN;
                    end
                end
                D_DRAIN: st <= D_IDLE;  // pixel 15 lands now
                default: st <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur <= fifo[rd_ptr];
        end
        wr_x <= cur.xpos + xpos_t'(pix);    // wraps at 512
    end

    assign rom_addr = {cur.bank, cur.offset, pix ^ {$bits(pix_idx_t){cur.hflip}}};

    // colour 0 is fetched but never written
    assign lb_we  = wr_pend && rom_data != '0;
    assign lb_x   = wr_x;
    assign lb_pix = '{prio: cur.prio, pal: cur.pal, color: rom_data};

endmodule

`default_nettype wire

/* obj_line_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module obj_line_buffer
    import obj_video_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            hstart,

    input  wire            lb_we,
    input  wire xpos_t     lb_x,
    input  wire lb_pixel_t lb_pix,

    output logic           pix_valid,
    output xpos_t          pix_x,
    output lb_pixel_t      pix
);

    lb_pixel_t mem [2*LB_SIZE];
    logic [2*LB_SIZE-1:0] filled;   // cleared flag reads back as zero
    logic      half;                // half being drawn
    logic      rd_on;
    xpos_t     rd_x;
    lb_addr_t  wr_addr;
    lb_addr_t  rd_addr;
    lb_pixel_t stored;
    logic      wr_ok;

    assign wr_addr = {half, lb_x};
    assign rd_addr = {~half, rd_x};     // other half holds the finished line
    assign stored  = filled[wr_addr] ? mem[wr_addr] : '0;
    // empty spot, or priority at least as high as what is there
    assign wr_ok   = stored.color == '0 || lb_pix.prio >= stored.prio;

    assign pix_valid = rd_on;
    assign pix_x     = rd_x;
    assign pix       = filled[rd_addr] ? mem[rd_addr] : '0;

    always_ff @(posedge clk) begin
        if (lb_we && wr_ok) begin
            mem[wr_addr] <= lb_pix;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            filled <= '0;
            half   <= 1'b0;
            rd_on  <= 1'b0;
            rd_x   <= '0;
        end else begin
            if (lb_we && wr_ok) begin
                filled[wr_addr] <= 1'b1;
            end
            if (rd_on) begin
                filled[rd_addr] <= 1'b0;   // clear behind the read
            end
            if (hstart) begin
                half  <= ~half;
                rd_on <= 1'b1;
                rd_x  <= '0;
            end else if (rd_on) begin
                rd_x <= rd_x + 1'b1;
                if (rd_x == xpos_t'(ACTIVE_WIDTH - 1)) begin
                    rd_on <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* obj_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module obj_subsys
    import obj_video_pkg::*;
    import obj_table_pkg::*;
(
    input  wire            clk,
    input  wire            rst,
    input  wire            hstart,
    input  wire vpos_t     vrender,

    input  wire            cpu_we,
    input  wire tbl_addr_t cpu_addr,
    input  wire tbl_word_t cpu_data,

    output rom_addr_t      rom_addr,
    input  wire color_t    rom_data,

    output logic           pix_valid,
    output xpos_t          pix_x,
    output lb_pixel_t      pix
);

    tbl_addr_t tbl_addr;
    logic      tbl_we;
    tbl_word_t tbl_din;
    tbl_word_t tbl_dout;

    logic      cmd_valid;
    draw_cmd_t cmd;
    logic      cmd_credit;

    logic      lb_we;
    xpos_t     lb_x;
    lb_pixel_t lb_pix;

    obj_table_ram u_table (
        .clk      (clk),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .tbl_addr (tbl_addr),
        .tbl_we   (tbl_we),
        .tbl_din  (tbl_din),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk        (clk),
        .rst        (rst),
        .hstart     (hstart),
        .vrender    (vrender),
        .tbl_addr   (tbl_addr),
        .tbl_we     (tbl_we),
        .tbl_din    (tbl_din),
        .tbl_dout   (tbl_dout),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .lb_we      (lb_we),
        .lb_x       (lb_x),
        .lb_pix     (lb_pix)
    );

    obj_line_buffer u_line_buffer (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .lb_we     (lb_we),
        .lb_x      (lb_x),
        .lb_pix    (lb_pix),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix       (pix)
    );

endmodule

`default_nettype wire

/* tb_obj_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_obj_subsys
    import obj_video_pkg::*;
    import obj_table_pkg::*;
();

    localparam int FRAMES         = 3;
    localparam int LINE_CYCLES    = 1024;   // hstart spacing
    localparam int LAST_LINE      = 225;    // vrender runs 0..225
    localparam int TIMEOUT_CYCLES = FRAMES * (LAST_LINE + 1) * LINE_CYCLES + 2000;

    logic      clk;
    logic      rst;
    logic      hstart;
    vpos_t     vrender;
    logic      cpu_we;
    tbl_addr_t cpu_addr;
    tbl_word_t cpu_data;
    rom_addr_t rom_addr;
    color_t    rom_data;
    logic      pix_valid;
    xpos_t     pix_x;
    lb_pixel_t pix;

    integer    seed = 60;
    tbl_word_t mirror [TBL_WORDS];      // copy of the object table
    lb_pixel_t exp_next [LB_SIZE];      // line being drawn now
    lb_pixel_t exp_stream [LB_SIZE];    // line being streamed now
    int        stream_cnt = 0;
    int        lines_streamed = 0;
    int        cycle_count = 0;

    obj_subsys obj_subsys_inst (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .vrender   (vrender),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pix_valid (pix_valid),
        .pix_x     (pix_x),
        .pix       (pix)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // pixel ROM contents with about a quarter of the pixels see-through
    function automatic color_t rom_color(input rom_addr_t a);
        logic [31:0] h;
        h = {9'd0, a} * 32'h9E37_79B1;
        h = h ^ (h >> 15);
        if (h[9:8] == 2'b00) begin
            return '0;
        end
        return color_t'(h[3:0]);
    endfunction

    function automatic tbl_addr_t entry_addr(input int obj, input word_idx_t w);
        return tbl_addr_t'(obj * 8 + int'(w));
    endfunction

    // random table loaded through the CPU port in 257 clock edges
    task automatic load_table();
        tbl_word_t w;
        for (int a = 0; a < TBL_WORDS; a++) begin
            w = $random(seed);
            case (word_idx_t'(a % 8))
                W_ATTR: begin
                    w[END_BIT]  = (($random(seed) & 63) == 0);     // rare end marker
                    w[HIDE_BIT] = (($random(seed) & 7) == 0);
                    w[TOP_LSB +: 9] = vpos_t'(($random(seed) & 255) % 232);
                end
                W_POS: if (($random(seed) & 7) == 0) begin
                    w[XPOS_LSB +: 9] = xpos_t'(500 + ($random(seed) & 7));  // near the wrap
                end
                W_SIZE: w[HEIGHT_LSB +: HEIGHT_W] = 8'($random(seed) & 127);
                default: ;
            endcase
            mirror[a] = w;
            @(posedge clk);
            cpu_we   <= 1'b1;
            cpu_addr <= tbl_addr_t'(a);
            cpu_data <= w;
        end
        @(posedge clk);
        cpu_we <= 1'b0;
    endtask

    // expected line v with objects drawn in table order
    task automatic draw_expected_line(input int v);
        tbl_word_t w0, w2, w5;
        int        top, height, pitch, xpos, idx, x;
        offset_t   off;
        bank_t     bank;
        prio_t     prio;
        pal_t      pal;
        logic      hflip;
        color_t    c;
        for (int o = 0; o < OBJ_COUNT; o++) begin
            w0 = mirror[entry_addr(o, W_ATTR)];
            w2 = mirror[entry_addr(o, W_POS)];
            w5 = mirror[entry_addr(o, W_SIZE)];
            if (w0[END_BIT]) begin
                break;
            end
            top    = w0[8:0];
            height = w5[15:8];
            if (w0[HIDE_BIT] || v < top || v >= top + height) begin
                continue;
            end
            pitch = w2[15:9];
            if (pitch >= 64) begin
                pitch -= 128;   // signed 7 bit step
            end
            off = mirror[entry_addr(o, W_OFFSET)];
            if (v != top) begin
                off = offset_t'(int'(off) + pitch);
            end
            mirror[entry_addr(o, W_OFFSET)] = off;
            bank  = w0[11:9];
            xpos  = w2[8:0];
            prio  = mirror[entry_addr(o, W_PRIO)][13:12];
            hflip = mirror[entry_addr(o, W_FLIP)][14];
            pal   = w5[6:0];
            for (int i = 0; i < 16; i++) begin
                idx = hflip ? 15 - i : i;
                c   = rom_color({bank, off, 4'(idx)});
                x   = (xpos + i) % LB_SIZE;
                if (c != 0 && (exp_next[x].color == 0 || prio >= exp_next[x].prio)) begin
                    exp_next[x] = '{prio: prio, pal: pal, color: c};
                end
            end
        end
    endtask

    // one line period with hstart on its first edge
    task automatic run_line(input int v, input bit load);
        int used;
        @(posedge clk);
        for (int x = 0; x < LB_SIZE; x++) begin
            exp_stream[x] = exp_next[x];    // drawn last line and streamed now
            exp_next[x]   = '0;
        end
        if (v <= LAST_ACTIVE_LINE) begin
            draw_expected_line(v);
        end
        hstart  <= 1'b1;
        vrender <= vpos_t'(v);
        @(posedge clk);
        hstart <= 1'b0;
        used = 1;
        if (load) begin
            load_table();
            used += 257;
        end
        repeat (LINE_CYCLES - 1 - used) @(posedge clk);
    endtask

    always @(posedge clk) begin
        rom_data <= rom_color(rom_addr);    // one cycle ROM latency
    end

    always @(negedge clk) begin
        if (!rst && hstart) begin
            assert (stream_cnt == (lines_streamed == 0 ? 0 : ACTIVE_WIDTH)) else
                stop_run($sformatf("Fail at %0t: line %0d streamed %0d pixels",
                                   $time, lines_streamed, stream_cnt));
            stream_cnt = 0;
            lines_streamed++;
        end
        if (pix_valid) begin
            assert (pix_x == xpos_t'(stream_cnt)) else
                stop_run($sformatf("Fail at %0t: pix_x %0d, expected %0d",
                                   $time, pix_x, stream_cnt));
            assert (pix == exp_stream[pix_x]) else
                stop_run($sformatf("Fail at %0t: x %0d expected %h got %h",
                                   $time, pix_x, exp_stream[pix_x], pix));
            stream_cnt++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        rst      = 1'b1;
        hstart   = 1'b0;
        vrender  = vpos_t'(LAST_LINE);   // blanking while the first table loads
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_data = '0;
        rom_data = '0;
        for (int x = 0; x < LB_SIZE; x++) begin
            exp_next[x]   = '0;
            exp_stream[x] = '0;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        load_table();
        for (int f = 0; f < FRAMES; f++) begin
            for (int v = 0; v <= LAST_LINE; v++) begin
                // new table in the first blank line
                run_line(v, v == LAST_ACTIVE_LINE + 1 && f < FRAMES - 1);
            end
        end
        assert (stream_cnt == ACTIVE_WIDTH) else
            stop_run($sformatf("Fail at %0t: last line streamed %0d pixels",
                               $time, stream_cnt));
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
obj_video_pkg.sv
obj_table_pkg.sv
obj_table_ram.sv
obj_scan.sv
obj_draw.sv
obj_line_buffer.sv
obj_subsys.sv
tb_obj_subsys.sv

/* Bender.yml */
package:
  name: obj_subsys

sources:
  - obj_video_pkg.sv
  - obj_table_pkg.sv
  - obj_table_ram.sv
  - obj_scan.sv
  - obj_draw.sv
  - obj_line_buffer.sv
  - obj_subsys.sv
  - target: test
    files:
      - tb_obj_subsys.sv
